// File: verilog/mvu_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared sizes, instruction fields and command types of the
// vector coprocessor, with the operand field union
//////////////////////////////////////////////////////////////////////
`default_nettype none

package mvu_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes

  localparam int unsigned NR_LANES       = 4;
  localparam int unsigned ELEN           = 32;
  localparam int unsigned VLMAX          = 16;
  localparam int unsigned ELEMS_PER_LANE = VLMAX / NR_LANES;
  localparam int unsigned NR_VREGS       = 8;
  // Must hold every length from 0 up to VLMAX
  localparam int unsigned VL_W           = $clog2(VLMAX + 1);
  localparam int unsigned BEAT_W         = $clog2(ELEMS_PER_LANE);
  localparam int unsigned REG_W          = 3;

  typedef logic [ELEN-1:0]   elen_t;
  typedef logic [VL_W-1:0]   vl_t;
  typedef logic [BEAT_W-1:0] beat_t;
  typedef logic [REG_W-1:0]  vreg_t;

  //////////////////////////////////////////////////////////////////////
  // Instruction encoding

  typedef enum logic [3:0] {
    OP_ADD   = 4'd0,
    OP_SUB   = 4'd1,
    OP_AND   = 4'd2,
    OP_OR    = 4'd3,
    OP_XOR   = 4'd4,
    OP_MV    = 4'd5,
    OP_SETVL = 4'd6,
    OP_EXT   = 4'd7
  } op_e;

  typedef enum logic [1:0] {
    SRC_VV = 2'd0,
    SRC_VX = 2'd1,
    SRC_VI = 2'd2
  } src_e;

  // Second operand field, a register index for VV and an immediate for VI
  typedef union packed {
    struct packed {
      logic [1:0] pad;
      vreg_t      vs1;
    } vr;
    logic signed [4:0] imm;
  } vopnd_u;

  typedef struct packed {
    op_e    op;
    src_e   src;
    logic   vm;    // 1 means unmasked
    vreg_t  vd;
    vreg_t  vs2;
    vopnd_u opnd;
  } insn_t;

  //////////////////////////////////////////////////////////////////////
  // Internal commands

  typedef struct packed {
    op_e    op;
    src_e   src;
    logic   vm;
    vreg_t  vd;
    vreg_t  vs2;
    vopnd_u opnd;
    elen_t  scalar;
    vl_t    vl;
    vl_t    nr_beats;
  } seq_cmd_t;

  typedef struct packed {
    logic   valid;
    op_e    op;
    src_e   src;
    logic   vm;
    vreg_t  vd;
    vreg_t  vs2;
    vopnd_u opnd;
    elen_t  scalar;
    vl_t    vl;
    beat_t  beat;
  } lane_cmd_t;

endpackage

`default_nettype wire

// File: verilog/mvu_beat_counter.sv
//////////////////////////////////////////////////////////////////////
// Element beat counter with a last-beat flag
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module mvu_beat_counter (
  input  wire                  clk_i,
  input  wire                  rst_n_i,
  input  wire                  start_i,
  input  wire                  step_i,
  input  wire mvu_pkg::vl_t    nr_beats_i,
  output mvu_pkg::beat_t       beat_o,
  output logic                 last_o
);

  mvu_pkg::beat_t beat_q;
  mvu_pkg::vl_t   target_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      beat_q   <= '0;
      target_q <= '0;
    end else if (start_i) begin
      beat_q   <= '0;
      target_q <= nr_beats_i;
    end else if (step_i) begin
      beat_q <= beat_q + 1'b1;
    end
  end

  assign beat_o = beat_q;
  // Never true for a zero target
  assign last_o = mvu_pkg::vl_t'(beat_q) == target_q - 1'b1;

  a_no_step_past_last : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) (step_i && !start_i) |-> !last_o
  ) else $error("Beat counter stepped past the last beat");

endmodule

`default_nettype wire

// File: verilog/mvu_lane.sv
//////////////////////////////////////////////////////////////////////
// One vector lane: register file slice, ALU, mask check and
// writeback stage
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module mvu_lane #(
  parameter int unsigned LANE_ID = 0
) (
  input  wire                       clk_i,
  input  wire                       rst_n_i,
  input  wire mvu_pkg::lane_cmd_t   lane_cmd_i,
  output mvu_pkg::elen_t            ext_data_o
);

  // Element e of this lane is element e * NR_LANES + LANE_ID of the vector
  mvu_pkg::elen_t rf_q [mvu_pkg::NR_VREGS][mvu_pkg::ELEMS_PER_LANE];

  mvu_pkg::elen_t vs2_val;
  mvu_pkg::elen_t opnd_val;
  mvu_pkg::elen_t old_vd;
  mvu_pkg::elen_t alu_res;
  logic           mask_bit;
  logic           is_arith;
  mvu_pkg::vl_t   elem_idx;
  logic           elem_we;

  logic           wb_we_q;
  mvu_pkg::vreg_t wb_vd_q;
  mvu_pkg::beat_t wb_beat_q;
  mvu_pkg::elen_t wb_data_q;

  //////////////////////////////////////////////////////////////////////
  // Read stage

  assign vs2_val  = rf_q[lane_cmd_i.vs2][lane_cmd_i.beat];
  assign old_vd   = rf_q[lane_cmd_i.vd][lane_cmd_i.beat];
  // Mask lives in bit 0 of each v0 element
  assign mask_bit = rf_q[0][lane_cmd_i.beat][0];

  always_comb begin
    unique case (lane_cmd_i.src)
      mvu_pkg::SRC_VV: opnd_val = rf_q[lane_cmd_i.opnd.vr.vs1][lane_cmd_i.beat];
      mvu_pkg::SRC_VX: opnd_val = lane_cmd_i.scalar;
      mvu_pkg::SRC_VI: opnd_val = {{(mvu_pkg::ELEN - $bits(lane_cmd_i.opnd.imm)){
                                     lane_cmd_i.opnd.imm[4]}}, lane_cmd_i.opnd.imm};
      default:         opnd_val = lane_cmd_i.scalar;
    endcase
  end

  always_comb begin
    unique case (lane_cmd_i.op)
      mvu_pkg::OP_ADD: alu_res = vs2_val + opnd_val;
      mvu_pkg::OP_SUB: alu_res = vs2_val - opnd_val;
      mvu_pkg::OP_AND: alu_res = vs2_val & opnd_val;
      mvu_pkg::OP_OR:  alu_res = vs2_val | opnd_val;
      mvu_pkg::OP_XOR: alu_res = vs2_val ^ opnd_val;
      mvu_pkg::OP_MV:  alu_res = opnd_val;
      // Anything else keeps the destination as it is
      default:         alu_res = old_vd;
    endcase
  end

  assign is_arith = lane_cmd_i.op inside {mvu_pkg::OP_ADD, mvu_pkg::OP_SUB, mvu_pkg::OP_AND,
                                          mvu_pkg::OP_OR, mvu_pkg::OP_XOR, mvu_pkg::OP_MV};

  assign elem_idx = mvu_pkg::vl_t'(lane_cmd_i.beat) * mvu_pkg::vl_t'(mvu_pkg::NR_LANES)
                  + mvu_pkg::vl_t'(LANE_ID);

  // Tail and masked-off elements stay undisturbed
  assign elem_we = lane_cmd_i.valid && is_arith && (elem_idx < lane_cmd_i.vl)
                && (lane_cmd_i.vm || mask_bit);

  //////////////////////////////////////////////////////////////////////
  // Writeback stage

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wb_we_q <= 1'b0;
    end else begin
      wb_we_q <= elem_we;
    end
  end

  always_ff @(posedge clk_i) begin
    if (lane_cmd_i.valid) begin
      wb_vd_q    <= lane_cmd_i.vd;
      wb_beat_q  <= lane_cmd_i.beat;
      wb_data_q  <= alu_res;
      ext_data_o <= vs2_val;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int r = 0; r < mvu_pkg::NR_VREGS; r++) begin
        for (int e = 0; e < mvu_pkg::ELEMS_PER_LANE; e++) begin
          rf_q[r][e] <= '0;
        end
      end
    end else if (wb_we_q) begin
      rf_q[wb_vd_q][wb_beat_q] <= wb_data_q;
    end
  end

endmodule

`default_nettype wire

// File: verilog/mvu_sequencer.sv
//////////////////////////////////////////////////////////////////////
// Sequencer FSM that expands one instruction into lane commands,
// one per element beat
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module mvu_sequencer (
  input  wire                       clk_i,
  input  wire                       rst_n_i,
  input  wire mvu_pkg::seq_cmd_t    seq_cmd_i,
  input  wire                       seq_valid_i,
  output logic                      seq_done_o,
  output mvu_pkg::lane_cmd_t        lane_cmd_o
);

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    DRAIN,
    FINISH
  } state_e;

  state_e            state_q;
  state_e            state_d;
  mvu_pkg::seq_cmd_t cmd_q;
  logic              start;
  logic              step;
  mvu_pkg::beat_t    beat;
  logic              last;

  mvu_beat_counter i_beat_counter (
    .clk_i      (clk_i             ),
    .rst_n_i    (rst_n_i           ),
    .start_i    (start             ),
    .step_i     (step              ),
    .nr_beats_i (seq_cmd_i.nr_beats),
    .beat_o     (beat              ),
    .last_o     (last              )
  );

  //////////////////////////////////////////////////////////////////////
  // FSM

  always_comb begin
    state_d = state_q;
    start   = 1'b0;
    step    = 1'b0;
    unique case (state_q)
      IDLE: begin
        if (seq_valid_i) begin
          start   = 1'b1;
          state_d = (seq_cmd_i.nr_beats == '0) ? FINISH : ISSUE;
        end
      end
      ISSUE: begin
        step = !last;
        if (last) begin
          state_d = DRAIN;
        end
      end
      // Last writeback retires at the end of this cycle
      DRAIN:   state_d = IDLE;
      FINISH:  state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      cmd_q <= seq_cmd_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Outputs

  assign seq_done_o = (state_q == DRAIN) || (state_q == FINISH);

  always_comb begin
    lane_cmd_o.valid  = state_q == ISSUE;
    lane_cmd_o.op     = cmd_q.op;
    lane_cmd_o.src    = cmd_q.src;
    lane_cmd_o.vm     = cmd_q.vm;
    lane_cmd_o.vd     = cmd_q.vd;
    lane_cmd_o.vs2    = cmd_q.vs2;
    lane_cmd_o.opnd   = cmd_q.opnd;
    lane_cmd_o.scalar = cmd_q.scalar;
    lane_cmd_o.vl     = cmd_q.vl;
    lane_cmd_o.beat   = beat;
  end

  // Every issued beat lies within the latched beat count
  a_beat_in_range : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
      lane_cmd_o.valid |-> mvu_pkg::vl_t'(beat) < cmd_q.nr_beats
  ) else $error("Lane command beat outside the beat count of the instruction");

  a_recv_only_idle : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) seq_valid_i |-> (state_q == IDLE)
  ) else $error("Dispatcher sent a command while the sequencer was busy");

endmodule

`default_nettype wire

// File: verilog/mvu_dispatcher.sv
//////////////////////////////////////////////////////////////////////
// Instruction decode, vector length register, busy level and
// scalar results towards the core
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module mvu_dispatcher (
  input  wire                                      clk_i,
  input  wire                                      rst_n_i,
  input  wire                                      insn_valid_i,
  input  wire mvu_pkg::insn_t                      insn_i,
  input  wire mvu_pkg::elen_t                      scalar_i,
  output logic                                     busy_o,
  output logic                                     done_o,
  output mvu_pkg::elen_t                           result_o,
  output logic                                     result_valid_o,
  // Sequencer side
  output mvu_pkg::seq_cmd_t                        seq_cmd_o,
  output logic                                     seq_valid_o,
  input  wire                                      seq_done_i,
  // Lane side
  input  wire mvu_pkg::elen_t [mvu_pkg::NR_LANES-1:0] ext_data_i
);

  mvu_pkg::vl_t                          vl_q;
  logic                                  busy_q;
  logic                                  setvl_done_q;
  logic                                  ext_pending_q;
  logic [$clog2(mvu_pkg::NR_LANES)-1:0]  ext_lane_q;

  logic                                  is_setvl;
  logic                                  is_ext;
  mvu_pkg::vl_t                          setvl_vl;
  logic [$clog2(mvu_pkg::VLMAX)-1:0]     ext_idx;
  mvu_pkg::vl_t                          nr_beats;

  //////////////////////////////////////////////////////////////////////
  // Decode

  assign is_setvl = insn_i.op == mvu_pkg::OP_SETVL;
  assign is_ext   = insn_i.op == mvu_pkg::OP_EXT;

  // Clamp the requested length to VLMAX
  assign setvl_vl = (scalar_i > mvu_pkg::elen_t'(mvu_pkg::VLMAX)) ?
                    mvu_pkg::vl_t'(mvu_pkg::VLMAX) : scalar_i[mvu_pkg::VL_W-1:0];

  // Element index of a scalar move wraps at VLMAX
  assign ext_idx = scalar_i[$clog2(mvu_pkg::VLMAX)-1:0];

  always_comb begin
    if (is_ext) begin
      // Walk up to the beat that holds element k
      nr_beats = mvu_pkg::vl_t'(ext_idx / mvu_pkg::NR_LANES) + mvu_pkg::vl_t'(1);
    end else begin
      nr_beats = mvu_pkg::vl_t'((vl_q + (mvu_pkg::NR_LANES - 1)) / mvu_pkg::NR_LANES);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // State

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vl_q          <= mvu_pkg::vl_t'(mvu_pkg::VLMAX);
      busy_q        <= 1'b0;
      setvl_done_q  <= 1'b0;
      seq_valid_o   <= 1'b0;
      ext_pending_q <= 1'b0;
      ext_lane_q    <= '0;
    end else begin
      setvl_done_q <= insn_valid_i && is_setvl;
      seq_valid_o  <= insn_valid_i && !is_setvl;
      if (insn_valid_i && is_setvl) begin
        vl_q <= setvl_vl;
      end
      // A new instruction may arrive in the cycle of the previous done
      if (insn_valid_i && !is_setvl) begin
        busy_q        <= 1'b1;
        ext_pending_q <= is_ext;
        ext_lane_q    <= ext_idx[$clog2(mvu_pkg::NR_LANES)-1:0];
      end else if (seq_done_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (insn_valid_i && !is_setvl) begin
      seq_cmd_o.op       <= insn_i.op;
      seq_cmd_o.src      <= insn_i.src;
      seq_cmd_o.vm       <= insn_i.vm;
      seq_cmd_o.vd       <= insn_i.vd;
      seq_cmd_o.vs2      <= insn_i.vs2;
      seq_cmd_o.opnd     <= insn_i.opnd;
      seq_cmd_o.scalar   <= scalar_i;
      seq_cmd_o.vl       <= vl_q;
      seq_cmd_o.nr_beats <= nr_beats;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Core outputs

  // Busy drops in the done cycle so the core can issue right away
  assign busy_o         = busy_q && !seq_done_i;
  assign done_o         = setvl_done_q || seq_done_i;
  assign result_valid_o = setvl_done_q || (seq_done_i && ext_pending_q);
  assign result_o       = setvl_done_q ? mvu_pkg::elen_t'(vl_q) : ext_data_i[ext_lane_q];

  a_no_insn_while_busy : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) insn_valid_i |-> !busy_o
  ) else $error("Instruction strobe while the coprocessor is busy");

  a_done_needs_pending : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) seq_done_i |-> busy_q
  ) else $error("Sequencer done without a pending instruction");

endmodule

`default_nettype wire

// File: verilog/mvu_top.sv
//////////////////////////////////////////////////////////////////////
// Vector coprocessor top level
// Dispatcher, sequencer and the array of lanes
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module mvu_top (
  input  wire                    clk_i,
  input  wire                    rst_n_i,
  // Core side
  input  wire                    insn_valid_i,
  input  wire mvu_pkg::insn_t    insn_i,
  input  wire mvu_pkg::elen_t    scalar_i,
  output logic                   busy_o,
  output logic                   done_o,
  output mvu_pkg::elen_t         result_o,
  output logic                   result_valid_o
);

  //////////////////////////////////////////////////////////////////////
  // Dispatcher

  mvu_pkg::seq_cmd_t                            seq_cmd;
  logic                                         seq_valid;
  logic                                         seq_done;
  mvu_pkg::elen_t [mvu_pkg::NR_LANES-1:0]       ext_data;

  mvu_dispatcher i_dispatcher (
    .clk_i          (clk_i         ),
    .rst_n_i        (rst_n_i       ),
    .insn_valid_i   (insn_valid_i  ),
    .insn_i         (insn_i        ),
    .scalar_i       (scalar_i      ),
    .busy_o         (busy_o        ),
    .done_o         (done_o        ),
    .result_o       (result_o      ),
    .result_valid_o (result_valid_o),
    .seq_cmd_o      (seq_cmd       ),
    .seq_valid_o    (seq_valid     ),
    .seq_done_i     (seq_done      ),
    .ext_data_i     (ext_data      )
  );

  //////////////////////////////////////////////////////////////////////
  // Sequencer

  mvu_pkg::lane_cmd_t lane_cmd;

  mvu_sequencer i_sequencer (
    .clk_i       (clk_i    ),
    .rst_n_i     (rst_n_i  ),
    .seq_cmd_i   (seq_cmd  ),
    .seq_valid_i (seq_valid),
    .seq_done_o  (seq_done ),
    .lane_cmd_o  (lane_cmd )
  );

  //////////////////////////////////////////////////////////////////////
  // Lanes

  // All lanes see the same command and pick their own elements
  for (genvar lane = 0; lane < mvu_pkg::NR_LANES; lane++) begin : gen_lanes
    mvu_lane #(
      .LANE_ID (lane)
    ) i_lane (
      .clk_i      (clk_i         ),
      .rst_n_i    (rst_n_i       ),
      .lane_cmd_i (lane_cmd      ),
      .ext_data_o (ext_data[lane])
    );
  end : gen_lanes

endmodule

`default_nettype wire

// File: tb/tb_mvu_model.svh
//////////////////////////////////////////////////////////////////////
// Reference model of the vector register file and vector length
//////////////////////////////////////////////////////////////////////
`ifndef TB_MVU_MODEL_SVH
`define TB_MVU_MODEL_SVH

mvu_pkg::elen_t ref_rf [mvu_pkg::NR_VREGS][mvu_pkg::VLMAX];
int unsigned    ref_vl;

task automatic clear_model();
  for (int r = 0; r < mvu_pkg::NR_VREGS; r++) begin
    for (int e = 0; e < mvu_pkg::VLMAX; e++) begin
      ref_rf[r][e] = '0;
    end
  end
  ref_vl = mvu_pkg::VLMAX;
endtask

function automatic mvu_pkg::elen_t clamp_vl(input mvu_pkg::elen_t req);
  return (req > mvu_pkg::VLMAX) ? mvu_pkg::VLMAX : req;
endfunction

// Scalar move index wraps at the register length
function automatic mvu_pkg::elen_t ext_element(input mvu_pkg::vreg_t vs2,
                                               input mvu_pkg::elen_t idx);
  return ref_rf[vs2][idx % mvu_pkg::VLMAX];
endfunction

// Tail and masked-off elements keep their old value
task automatic apply_insn(input mvu_pkg::insn_t insn, input mvu_pkg::elen_t scalar);
  mvu_pkg::elen_t a;
  mvu_pkg::elen_t b;
  int             imm_val;
  if (insn.op == mvu_pkg::OP_SETVL) begin
    ref_vl = clamp_vl(scalar);
  end else if (insn.op != mvu_pkg::OP_EXT) begin
    for (int e = 0; e < ref_vl; e++) begin
      if (insn.vm || ref_rf[0][e][0]) begin
        a       = ref_rf[insn.vs2][e];
        imm_val = $signed(insn.opnd.imm);
        case (insn.src)
          mvu_pkg::SRC_VV: b = ref_rf[insn.opnd.vr.vs1][e];
          mvu_pkg::SRC_VI: b = imm_val;
          default:         b = scalar;
        endcase
        case (insn.op)
          mvu_pkg::OP_ADD: ref_rf[insn.vd][e] = a + b;
          mvu_pkg::OP_SUB: ref_rf[insn.vd][e] = a - b;
          mvu_pkg::OP_AND: ref_rf[insn.vd][e] = a & b;
          mvu_pkg::OP_OR:  ref_rf[insn.vd][e] = a | b;
          mvu_pkg::OP_XOR: ref_rf[insn.vd][e] = a ^ b;
          default:         ref_rf[insn.vd][e] = b;
        endcase
      end
    end
  end
endtask

`endif

// File: tb/tb_mvu.sv
//////////////////////////////////////////////////////////////////////
// Testbench of the vector coprocessor, with stimulus, checks,
// watchdog and the final report
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_mvu;

  localparam int HALF_PERIOD     = 4;
  localparam int DRIVE_DLY       = 1;
  localparam int RESET_CYCLES    = 8;
  localparam int DONE_LIMIT      = mvu_pkg::VLMAX + 10;
  // About 730 instructions in all tests, rounded up
  localparam int MAX_INSNS       = 800;
  localparam int WATCHDOG_CYCLES = MAX_INSNS * DONE_LIMIT + 1000;

  logic           clk = 1'b0;
  logic           rst_n;
  logic           insn_valid;
  mvu_pkg::insn_t insn_word;
  mvu_pkg::elen_t scalar_word;
  logic           busy;
  logic           done;
  mvu_pkg::elen_t result;
  logic           result_valid;

  int             seed = 32'h3564_afdc;
  int             errors = 0;
  int             test_errors = 0;
  int             n_tests = 0;
  int             n_insn = 0;
  string          test_name = "reset";

  // Expectations of the instruction in flight
  logic           pending;
  logic           exp_arith;
  logic           exp_rv;
  mvu_pkg::elen_t exp_result;
  int unsigned    exp_lat;
  int unsigned    strobe_cyc;
  int unsigned    cyc = 0;

  `include "tb_mvu_model.svh"

  mvu_top DUT (
    .clk_i          (clk         ),
    .rst_n_i        (rst_n       ),
    .insn_valid_i   (insn_valid  ),
    .insn_i         (insn_word   ),
    .scalar_i       (scalar_word ),
    .busy_o         (busy        ),
    .done_o         (done        ),
    .result_o       (result      ),
    .result_valid_o (result_valid)
  );

  always #HALF_PERIOD clk = ~clk;

  // Counted on the falling edge so it is stable at every rising edge
  always @(negedge clk) cyc <= cyc + 1;

  //////////////////////////////////////////////////////////////////////
  // Checks

  a_quiet_when_idle : assert property (
    @(posedge clk) disable iff (!rst_n) !pending |-> !busy && !done && !result_valid
  ) else begin
    errors++;
    $display("%s: busy, done or result valid high with no instruction pending", test_name);
  end

  a_busy_until_done : assert property (
    @(posedge clk) disable iff (!rst_n)
      pending && exp_arith && (cyc > strobe_cyc) && !done |-> busy
  ) else begin
    errors++;
    $display("%s: busy_o low before done_o", test_name);
  end

  a_busy_drops_at_done : assert property (
    @(posedge clk) disable iff (!rst_n) done |-> !busy
  ) else begin
    errors++;
    $display("%s: busy_o still high in the done cycle", test_name);
  end

  a_done_latency : assert property (
    @(posedge clk) disable iff (!rst_n) done && (exp_lat != 0) |-> cyc == strobe_cyc + exp_lat
  ) else begin
    errors++;
    $display("mismatch %s: done cycle expected %0d, actual %0d", test_name,
             strobe_cyc + exp_lat, cyc);
  end

  a_result_valid : assert property (
    @(posedge clk) disable iff (!rst_n)
      done || result_valid |-> done && (result_valid == exp_rv)
  ) else begin
    errors++;
    $display("mismatch %s: result_valid_o expected %0b, actual %0b", test_name,
             exp_rv, $sampled(result_valid));
  end

  a_result_value : assert property (
    @(posedge clk) disable iff (!rst_n) result_valid |-> result == exp_result
  ) else begin
    errors++;
    $display("mismatch %s: result expected 0x%08h, actual 0x%08h", test_name,
             exp_result, $sampled(result));
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers

  function automatic mvu_pkg::insn_t make_insn(input mvu_pkg::op_e op,
      input mvu_pkg::src_e src, input logic vm, input mvu_pkg::vreg_t vd,
      input mvu_pkg::vreg_t vs2, input logic [4:0] opnd);
    mvu_pkg::insn_t insn;
    insn.op       = op;
    insn.src      = src;
    insn.vm       = vm;
    insn.vd       = vd;
    insn.vs2      = vs2;
    insn.opnd.imm = opnd;
    return insn;
  endfunction

  // Any register but v0, which holds the mask
  function automatic mvu_pkg::vreg_t rand_vreg();
    int unsigned r;
    r = $random(seed);
    return mvu_pkg::vreg_t'(1 + r % (mvu_pkg::NR_VREGS - 1));
  endfunction

  task automatic issue(input mvu_pkg::insn_t insn, input mvu_pkg::elen_t scalar);
    int unsigned nr_beats;
    int          waited;
    nr_beats   = (ref_vl + mvu_pkg::NR_LANES - 1) / mvu_pkg::NR_LANES;
    exp_arith  = insn.op inside {mvu_pkg::OP_ADD, mvu_pkg::OP_SUB, mvu_pkg::OP_AND,
                                 mvu_pkg::OP_OR, mvu_pkg::OP_XOR, mvu_pkg::OP_MV};
    exp_rv     = (insn.op == mvu_pkg::OP_SETVL) || (insn.op == mvu_pkg::OP_EXT);
    exp_lat    = 0;
    exp_result = '0;
    if (insn.op == mvu_pkg::OP_SETVL) begin
      exp_lat    = 1;
      exp_result = clamp_vl(scalar);
    end else if (insn.op == mvu_pkg::OP_EXT) begin
      exp_result = ext_element(insn.vs2, scalar);
    end else begin
      exp_lat = nr_beats + 2;
    end
    // Count seen at the edge that samples the strobe
    strobe_cyc  = cyc + 1;
    pending     = 1'b1;
    insn_valid  = 1'b1;
    insn_word   = insn;
    scalar_word = scalar;
    @(posedge clk);
    #DRIVE_DLY;
    insn_valid = 1'b0;
    apply_insn(insn, scalar);
    waited = 0;
    while (!done && waited < DONE_LIMIT) begin
      @(posedge clk);
      #DRIVE_DLY;
      waited++;
    end
    if (!done) begin
      errors++;
      $display("%s: no done_o within %0d cycles", test_name, DONE_LIMIT);
    end
    // Let the done edge pass before the next strobe
    @(posedge clk);
    #DRIVE_DLY;
    pending = 1'b0;
    n_insn++;
  endtask

  task automatic set_vl(input mvu_pkg::elen_t len);
    issue(make_insn(mvu_pkg::OP_SETVL, mvu_pkg::SRC_VX, 1'b1, '0, '0, '0), len);
  endtask

  task automatic splat(input mvu_pkg::vreg_t vd, input mvu_pkg::elen_t value);
    issue(make_insn(mvu_pkg::OP_MV, mvu_pkg::SRC_VX, 1'b1, vd, '0, '0), value);
  endtask

  // Shrinking vl leaves a different random value in every element
  task automatic fill_varied(input mvu_pkg::vreg_t vd);
    for (int n = mvu_pkg::VLMAX; n >= 1; n--) begin
      set_vl(n);
      splat(vd, $random(seed));
    end
    set_vl(mvu_pkg::VLMAX);
  endtask

  // High index bits are random to exercise the wrap
  task automatic read_back_reg(input mvu_pkg::vreg_t vs2);
    mvu_pkg::elen_t idx;
    for (int k = 0; k < mvu_pkg::VLMAX; k++) begin
      idx      = $random(seed);
      idx[3:0] = k[3:0];
      issue(make_insn(mvu_pkg::OP_EXT, mvu_pkg::SRC_VX, 1'b1, '0, vs2, '0), idx);
    end
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = errors;
  endtask

  task automatic end_test();
    $display("%s finished with %0d failed check(s)", test_name, errors - test_errors);
    n_tests++;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests

  task automatic check_reset_and_setvl();
    begin_test("setvl");
    repeat (3) @(posedge clk);
    #DRIVE_DLY;
    set_vl(32'd0);
    set_vl(32'd7);
    set_vl(32'd100);
    end_test();
  endtask

  task automatic fill_and_read_back();
    begin_test("fill");
    set_vl(mvu_pkg::VLMAX);
    for (int r = 0; r < mvu_pkg::NR_VREGS; r++) begin
      splat(mvu_pkg::vreg_t'(r), $random(seed));
    end
    for (int r = 0; r < mvu_pkg::NR_VREGS; r++) begin
      read_back_reg(mvu_pkg::vreg_t'(r));
    end
    end_test();
  endtask

  task automatic run_arith_forms();
    mvu_pkg::op_e   ops [5];
    mvu_pkg::src_e  src;
    mvu_pkg::vreg_t vd;
    mvu_pkg::vreg_t vs2;
    logic [4:0]     opnd;
    ops = '{mvu_pkg::OP_ADD, mvu_pkg::OP_SUB, mvu_pkg::OP_AND, mvu_pkg::OP_OR, mvu_pkg::OP_XOR};
    begin_test("arith");
    for (int r = 1; r < mvu_pkg::NR_VREGS; r++) begin
      fill_varied(mvu_pkg::vreg_t'(r));
    end
    for (int i = 0; i < 5; i++) begin
      for (int j = 0; j < 3; j++) begin
        src  = mvu_pkg::src_e'(j);
        vd   = rand_vreg();
        vs2  = rand_vreg();
        opnd = 5'($random(seed));
        if (src == mvu_pkg::SRC_VV) begin
          opnd = {2'b00, rand_vreg()};
        end else if (src == mvu_pkg::SRC_VI) begin
          // Every other op gets a negative immediate
          opnd[4] = i[0];
        end
        issue(make_insn(ops[i], src, 1'b1, vd, vs2, opnd), $random(seed));
        read_back_reg(vd);
      end
    end
    end_test();
  endtask

  task automatic run_masked_add();
    mvu_pkg::vreg_t vd;
    mvu_pkg::vreg_t vs2;
    mvu_pkg::vreg_t vs1;
    begin_test("mask");
    fill_varied('0);
    for (int j = 0; j < 2; j++) begin
      vd  = rand_vreg();
      vs2 = rand_vreg();
      vs1 = rand_vreg();
      issue(make_insn(mvu_pkg::OP_ADD, mvu_pkg::src_e'(j), 1'b0, vd, vs2, {2'b00, vs1}),
            $random(seed));
      read_back_reg(vd);
    end
    end_test();
  endtask

  task automatic run_tail_cases();
    mvu_pkg::vreg_t vd;
    mvu_pkg::vreg_t vs2;
    mvu_pkg::vreg_t vs1;
    begin_test("tail");
    vd  = rand_vreg();
    vs2 = rand_vreg();
    vs1 = rand_vreg();
    set_vl(32'd5);
    issue(make_insn(mvu_pkg::OP_ADD, mvu_pkg::SRC_VV, 1'b1, vd, vs2, {2'b00, vs1}), '0);
    read_back_reg(vd);
    set_vl(32'd0);
    issue(make_insn(mvu_pkg::OP_ADD, mvu_pkg::SRC_VX, 1'b1, vd, vs2, '0), $random(seed));
    read_back_reg(vd);
    set_vl(mvu_pkg::VLMAX);
    end_test();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog

  initial begin
    rst_n       = 1'b0;
    insn_valid  = 1'b0;
    insn_word   = '0;
    scalar_word = '0;
    pending     = 1'b0;
    exp_arith   = 1'b0;
    exp_rv      = 1'b0;
    exp_result  = '0;
    exp_lat     = 0;
    strobe_cyc  = 0;
    clear_model();
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
    check_reset_and_setvl();
    fill_and_read_back();
    run_arith_forms();
    run_masked_add();
    run_tail_cases();
    $display("Summary: %0d tests, %0d instructions, %0d errors", n_tests, n_insn, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run is stuck", WATCHDOG_CYCLES);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+tb
verilog/mvu_pkg.sv
verilog/mvu_beat_counter.sv
verilog/mvu_lane.sv
verilog/mvu_sequencer.sv
verilog/mvu_dispatcher.sv
verilog/mvu_top.sv
tb/tb_mvu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the vector coprocessor testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mvu -Mdir "$BUILD_DIR" -f vlog.f

"./$BUILD_DIR/Vtb_mvu" | tee "$LOG_FILE"

# The testbench prints the pass line only when every check held
if grep -qx "Test OK" "$LOG_FILE"; then
  echo "Simulation passed"
else
  echo "Simulation failed, see $LOG_FILE"
  exit 1
fi
